//--- logic/uartLinePkg.sv
// ----------------------------------------------------------------------
// Serial line format definitions
//   word length and parity mode encodings
//   frame configuration shared by transmitter and receiver
//   received character with its error flags
//   helpers for data bit count and parity bit value
// ----------------------------------------------------------------------

package uartLinePkg;

	// data bits per character, encoded as the CTRL word length field
	typedef enum logic [1:0] {
		WL_8 = 2'd0,
		WL_7 = 2'd1,
		WL_6 = 2'd2,
		WL_5 = 2'd3
	} wordLen_t;

	// bit 0 set means a parity bit is on the line
	typedef enum logic [2:0] {
		PAR_NONE  = 3'b000,
		PAR_ODD   = 3'b001,
		PAR_EVEN  = 3'b011,
		PAR_MARK  = 3'b101,	// forced 1
		PAR_SPACE = 3'b111	// forced 0
	} parity_t;

	typedef struct packed {
		wordLen_t wordLen;
		parity_t  parity;
		logic     stop2;	// 0 one stop bit, 1 two
	} frameCfg_t;

	typedef struct packed {
		logic       frameErr;
		logic       parityErr;
		logic [7:0] data;	// upper bits zero for short words
	} rxChar_t;

	// 8 down to 5
	function automatic logic [3:0] dataBits(wordLen_t wl);
		return 4'd8 - {2'b00, wl};
	endfunction

	// parity bit for already masked data
	function automatic logic parityBit(parity_t mode, logic [7:0] d);
		case (mode)
			PAR_ODD:  return ~^d;	// odd number of ones incl. parity
			PAR_EVEN: return ^d;
			PAR_MARK: return 1'b1;
			default:  return 1'b0;	// forced 0, or unused
		endcase
	endfunction

endpackage

//--- logic/uartHostPkg.sv
// ----------------------------------------------------------------------
// Host register map definitions
//   register addresses and the single-cycle bus request
//   status byte layout
//   command and control register layouts
// ----------------------------------------------------------------------

package uartHostPkg;

	typedef logic [2:0] regAdr_t;

	localparam regAdr_t ADR_DATA  = 3'd0;	// tx hold on write, rx hold on read
	localparam regAdr_t ADR_STAT  = 3'd1;	// write is a soft reset
	localparam regAdr_t ADR_CMD   = 3'd2;
	localparam regAdr_t ADR_CTRL  = 3'd3;
	localparam regAdr_t ADR_DIVLO = 3'd4;
	localparam regAdr_t ADR_DIVHI = 3'd5;

	// one clock strobe, no acknowledge
	typedef struct packed {
		logic       cs;
		logic       we;
		regAdr_t    adr;
		logic [7:0] dat;
	} busReq_t;

	// bit 7 down to bit 0
	typedef struct packed {
		logic irq;
		logic txIdle;
		logic txLost;
		logic txHoldEmpty;
		logic rxFull;
		logic overrun;
		logic frameErr;
		logic parityErr;
	} statBits_t;

	// ----------------------------------------------------------------------
	// command register
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic [2:0] parity;	// line parity mode code
		logic       loop;	// local loopback
		logic [1:0] txCtl;
		logic       rxIe;
		logic       spare;	// kept for readback
	} cmdReg_t;

	localparam logic [1:0] TXC_IE = 2'b01;	// only code that enables tx irq

	// ----------------------------------------------------------------------
	// control register
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic       stop2;
		logic [1:0] wlCode;	// 00=8 01=7 10=6 11=5
		logic [4:0] spare;	// stored, no function
	} ctrlReg_t;

endpackage

//--- logic/uartHoldReg.sv
// ----------------------------------------------------------------------
// One-entry holding register
//   full flag, sticky flag for loads that found it full
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module uartHoldReg #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     load_i,
	input  payload_t data_i,
	input  logic     take_i,
	output payload_t data_o,
	output logic     full_o,
	output logic     dropped_o
);

	logic room;

	assign room = ~full_o | take_i;	// a take frees the slot this same edge

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			full_o    <= 1'b0;
			dropped_o <= 1'b0;
		end else begin
			if (load_i & room)
				full_o <= 1'b1;
			else if (take_i)
				full_o <= 1'b0;
			if (load_i & ~room)
				dropped_o <= 1'b1;	// held entry kept
			else if (take_i)
				dropped_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load_i & room)
			data_o <= data_i;
	end

endmodule

//--- logic/uartBaudGen.sv
// ----------------------------------------------------------------------
// Baud generator
//   free running divider, one clock tick16 per divisor period
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module uartBaudGen #(
	parameter int pDivBits = 16
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic [pDivBits-1:0] div_i,
	output logic                tick16_o
);

	logic [pDivBits-1:0] cnt;
	logic [pDivBits-1:0] divEff;
	logic                wrap;

	assign divEff = (div_i == '0) ? pDivBits'(1) : div_i;	// zero behaves as one
	assign wrap   = (cnt >= divEff);	// >= so a smaller divisor takes effect at once

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt      <= pDivBits'(1);
			tick16_o <= 1'b0;
		end else begin
			tick16_o <= wrap;
			if (wrap)
				cnt <= pDivBits'(1);	// count runs 1..div
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

//--- logic/uartTx.sv
// ----------------------------------------------------------------------
// Transmitter
//   byte holding register
//   frame serializer with start, 5..8 data bits, parity and 1 or 2 stop bits
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module uartTx (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  tick16_i,
	input  uartLinePkg::frameCfg_t frame_i,
	input  logic                  load_i,
	input  logic [7:0]            data_i,
	output logic                  holdFull_o,
	output logic                  lost_o,
	output logic                  idle_o,
	output logic                  txd_o
);

	logic [7:0]  holdData;
	logic [7:0]  maskedData;
	logic [3:0]  nBits;
	logic [3:0]  frameLen;	// bits on the line incl. start and stop
	logic [3:0]  bitsLeft;
	logic [3:0]  tickCnt;	// 16 ticks per bit
	logic [11:0] frameBits;
	logic [11:0] shiftReg;
	logic        parBit;
	logic        take;
	logic        txdReg;

	uartHoldReg #(
		.payload_t(logic [7:0])
	) txHold (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.load_i   (load_i),
		.data_i   (data_i),
		.take_i   (take),
		.data_o   (holdData),
		.full_o   (holdFull_o),
		.dropped_o(lost_o)
	);

	assign nBits      = uartLinePkg::dataBits(frame_i.wordLen);
	assign maskedData = holdData & (8'hFF >> frame_i.wordLen);
	assign parBit     = uartLinePkg::parityBit(frame_i.parity, maskedData);
	assign frameLen   = 4'd2 + nBits + {3'b000, frame_i.parity[0]} + {3'b000, frame_i.stop2};

	assign idle_o = (bitsLeft == 4'd0);
	assign take   = idle_o & holdFull_o & tick16_i;	// start bit aligns to a tick
	assign txd_o  = txdReg;

	// ----------------------------------------------------------------------
	// frame image with the LSB going out first
	// ----------------------------------------------------------------------
	always_comb begin
		frameBits    = '1;	// stop bits and fill are high
		frameBits[0] = 1'b0;	// start
		for (int i = 0; i < 8; i++) begin
			if (4'(i) < nBits)
				frameBits[i+1] = maskedData[i];
		end
		if (frame_i.parity[0])
			frameBits[nBits+4'd1] = parBit;	// right after the last data bit
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bitsLeft <= 4'd0;
			tickCnt  <= 4'd0;
			txdReg   <= 1'b1;	// line idles high
		end else if (take) begin
			shiftReg <= {1'b1, frameBits[11:1]};
			txdReg   <= frameBits[0];
			bitsLeft <= frameLen;
			tickCnt  <= 4'd0;
		end else if (!idle_o && tick16_i) begin
			tickCnt <= tickCnt + 4'd1;
			if (tickCnt == 4'd15) begin	// end of a bit period
				txdReg   <= shiftReg[0];
				shiftReg <= {1'b1, shiftReg[11:1]};	// ones shift in so the line ends high
				bitsLeft <= bitsLeft - 4'd1;
			end
		end
	end

endmodule

//--- logic/uartRx.sv
// ----------------------------------------------------------------------
// Receiver
//   line synchronizer and start bit detect with glitch check
//   16x oversampled bit sampling at bit centers
//   parity and stop checks, holding register with overrun
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module uartRx (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  tick16_i,
	input  uartLinePkg::frameCfg_t frame_i,
	input  logic                  rxd_i,
	input  logic                  take_i,
	output uartLinePkg::rxChar_t   char_o,
	output logic                  full_o,
	output logic                  overrun_o
);

	logic [2:0]           rxSync;	// two sync flops plus one for the edge
	logic                 line;
	logic                 fall;
	logic                 busy;
	logic                 sample;
	logic                 lastBit;
	logic [3:0]           tickCnt;
	logic [3:0]           bitIdx;	// 0 is the start bit
	logic [3:0]           nBits;
	logic [3:0]           parIdx;
	logic [3:0]           lastIdx;
	logic [7:0]           dataReg;
	logic                 parErr;
	logic                 frmErr;
	uartLinePkg::rxChar_t newChar;

	// ----------------------------------------------------------------------
	// line conditioning
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i)
			rxSync <= 3'b111;
		else
			rxSync <= {rxSync[1:0], rxd_i};
	end

	assign line = rxSync[1];
	assign fall = rxSync[2] & ~rxSync[1];

	// ----------------------------------------------------------------------
	// frame position
	// ----------------------------------------------------------------------
	assign nBits   = uartLinePkg::dataBits(frame_i.wordLen);
	assign parIdx  = nBits + 4'd1;
	assign lastIdx = nBits + 4'd1 + {3'b000, frame_i.parity[0]} + {3'b000, frame_i.stop2};

	assign sample  = busy & tick16_i & (tickCnt == 4'd15);	// bit center
	assign lastBit = sample & (bitIdx == lastIdx);	// middle of final stop bit

	assign newChar = '{
		frameErr:  frmErr | ~line,	// include the stop bit being sampled now
		parityErr: parErr,
		data:      dataReg
	};

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy    <= 1'b0;
			tickCnt <= 4'd0;
			bitIdx  <= 4'd0;
		end else if (!busy) begin
			if (fall) begin
				busy    <= 1'b1;
				tickCnt <= 4'd8;	// first sample 8 ticks on, mid start bit
				bitIdx  <= 4'd0;
			end
		end else begin
			if (tick16_i)
				tickCnt <= tickCnt + 4'd1;	// wraps, next sample 16 ticks later
			if (sample)
				bitIdx <= bitIdx + 4'd1;
			if (sample && bitIdx == 4'd0 && line)
				busy <= 1'b0;	// start bit gone, glitch
			if (lastBit)
				busy <= 1'b0;
		end
	end

	// payload of the frame under way, cleared at each start edge
	always_ff @(posedge clk_i) begin
		if (!busy && fall) begin
			dataReg <= 8'h00;	// unused high bits read as zero
			parErr  <= 1'b0;
			frmErr  <= 1'b0;
		end else if (sample && bitIdx != 4'd0) begin
			if (bitIdx <= nBits)
				dataReg[3'(bitIdx - 4'd1)] <= line;	// LSB first
			else if (frame_i.parity[0] && bitIdx == parIdx)
				parErr <= line != uartLinePkg::parityBit(frame_i.parity, dataReg);
			else if (!line)
				frmErr <= 1'b1;	// stop bit low
		end
	end

	// dropped load doubles as overrun
	uartHoldReg #(
		.payload_t(uartLinePkg::rxChar_t)
	) rxHold (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.load_i   (lastBit),
		.data_i   (newChar),
		.take_i   (take_i),
		.data_o   (char_o),
		.full_o   (full_o),
		.dropped_o(overrun_o)
	);

endmodule

//--- logic/uartRegs.sv
// ----------------------------------------------------------------------
// Host register block
//   bus strobe decode, CMD / CTRL / divisor registers
//   read mux and status byte
//   level interrupt and local loopback
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module uartRegs #(
	parameter int pDivBits    = 16,
	parameter int pDefaultDiv = 27
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  uartHostPkg::busReq_t   bus_i,
	output logic [7:0]             rdat_o,
	output uartLinePkg::frameCfg_t frame_o,
	output logic [pDivBits-1:0]    div_o,
	output logic                   txLoad_o,
	output logic [7:0]             txData_o,
	input  logic                   txHoldFull_i,
	input  logic                   txLost_i,
	input  logic                   txIdle_i,
	output logic                   rxTake_o,
	input  uartLinePkg::rxChar_t   rxChar_i,
	input  logic                   rxFull_i,
	input  logic                   overrun_i,
	input  logic                   txSerial_i,
	input  logic                   rxd_i,
	output logic                   rxLine_o,
	output logic                   txd_o,
	output logic                   irq_o
);

	uartHostPkg::cmdReg_t   cmdReg;
	uartHostPkg::ctrlReg_t  ctrlReg;
	uartHostPkg::statBits_t stat;
	logic [pDivBits-1:0]    divReg;
	logic [15:0]            divWide;	// byte view of the divisor
	logic [7:0]             rdMux;
	logic                   wrStb;
	logic                   rdStb;
	logic                   txIe;

	assign wrStb = bus_i.cs & bus_i.we;
	assign rdStb = bus_i.cs & ~bus_i.we;

	// transmit load and receive take, same cycle as the strobe
	assign txLoad_o = wrStb & (bus_i.adr == uartHostPkg::ADR_DATA);
	assign txData_o = bus_i.dat;
	assign rxTake_o = rdStb & (bus_i.adr == uartHostPkg::ADR_DATA);

	assign txIe    = (cmdReg.txCtl == uartHostPkg::TXC_IE);
	assign divWide = 16'(divReg);
	assign div_o   = divReg;

	assign frame_o = '{
		wordLen: uartLinePkg::wordLen_t'(ctrlReg.wlCode),
		parity:  uartLinePkg::parity_t'(cmdReg.parity),
		stop2:   ctrlReg.stop2
	};

	// ----------------------------------------------------------------------
	// register writes
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cmdReg  <= '0;	// no parity, irqs and loopback off
			ctrlReg <= '0;	// 8 bits, one stop
			divReg  <= pDivBits'(pDefaultDiv);
		end else if (wrStb) begin
			case (bus_i.adr)
				uartHostPkg::ADR_STAT: begin	// soft reset
					cmdReg.rxIe  <= 1'b0;
					cmdReg.txCtl <= 2'b00;
					cmdReg.loop  <= 1'b0;
				end
				uartHostPkg::ADR_CMD:   cmdReg  <= uartHostPkg::cmdReg_t'(bus_i.dat);
				uartHostPkg::ADR_CTRL:  ctrlReg <= uartHostPkg::ctrlReg_t'(bus_i.dat);
				uartHostPkg::ADR_DIVLO: divReg  <= pDivBits'({divWide[15:8], bus_i.dat});
				uartHostPkg::ADR_DIVHI: divReg  <= pDivBits'({bus_i.dat, divWide[7:0]});
				default: ;	// DATA goes to the transmitter
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// status and read back
	// ----------------------------------------------------------------------
	assign stat = '{
		irq:         irq_o,
		txIdle:      txIdle_i,
		txLost:      txLost_i,
		txHoldEmpty: ~txHoldFull_i,
		rxFull:      rxFull_i,
		overrun:     overrun_i,
		frameErr:    rxFull_i & rxChar_i.frameErr,	// flags belong to the held char
		parityErr:   rxFull_i & rxChar_i.parityErr
	};

	always_comb begin
		case (bus_i.adr)
			uartHostPkg::ADR_DATA:  rdMux = rxChar_i.data;
			uartHostPkg::ADR_STAT:  rdMux = stat;
			uartHostPkg::ADR_CMD:   rdMux = cmdReg;
			uartHostPkg::ADR_CTRL:  rdMux = ctrlReg;
			uartHostPkg::ADR_DIVLO: rdMux = divWide[7:0];
			uartHostPkg::ADR_DIVHI: rdMux = divWide[15:8];
			default:                rdMux = 8'h00;
		endcase
	end

	// value before any read side effect, held until the next read
	always_ff @(posedge clk_i) begin
		if (rst_i)
			rdat_o <= 8'h00;
		else if (rdStb)
			rdat_o <= rdMux;
	end

	// ----------------------------------------------------------------------
	// interrupt, one clock behind its cause
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i)
			irq_o <= 1'b0;
		else
			irq_o <= (cmdReg.rxIe & rxFull_i) | (txIe & ~txHoldFull_i);
	end

	// loopback: receiver listens to the transmitter, pin stays idle
	assign rxLine_o = cmdReg.loop ? txSerial_i : rxd_i;
	assign txd_o    = cmdReg.loop ? 1'b1 : txSerial_i;

endmodule

//--- logic/uartTop.sv
// ----------------------------------------------------------------------
// Serial port top level
//   baud generator, transmitter, receiver and host registers
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module uartTop #(
	parameter int pDivBits    = 16,
	parameter int pDefaultDiv = 27
) (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  uartHostPkg::busReq_t bus_i,
	output logic [7:0]           rdat_o,
	input  logic                 rxd_i,
	output logic                 txd_o,
	output logic                 irq_o
);

	uartLinePkg::frameCfg_t frame;
	uartLinePkg::rxChar_t   rxChar;
	logic [pDivBits-1:0]    div;
	logic                   tick16;
	logic                   txLoad;
	logic [7:0]             txData;
	logic                   txHoldFull;
	logic                   txLost;
	logic                   txIdle;
	logic                   txSerial;	// before the loopback switch
	logic                   rxTake;
	logic                   rxFull;
	logic                   overrun;
	logic                   rxLine;	// after the loopback switch

	uartBaudGen #(
		.pDivBits(pDivBits)
	) baudGen (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.div_i   (div),
		.tick16_o(tick16)
	);

	uartTx tx (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.tick16_i  (tick16),
		.frame_i   (frame),
		.load_i    (txLoad),
		.data_i    (txData),
		.holdFull_o(txHoldFull),
		.lost_o    (txLost),
		.idle_o    (txIdle),
		.txd_o     (txSerial)
	);

	uartRx rx (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.tick16_i (tick16),
		.frame_i  (frame),
		.rxd_i    (rxLine),
		.take_i   (rxTake),
		.char_o   (rxChar),
		.full_o   (rxFull),
		.overrun_o(overrun)
	);

	uartRegs #(
		.pDivBits   (pDivBits),
		.pDefaultDiv(pDefaultDiv)
	) regs (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.bus_i       (bus_i),
		.rdat_o      (rdat_o),
		.frame_o     (frame),
		.div_o       (div),
		.txLoad_o    (txLoad),
		.txData_o    (txData),
		.txHoldFull_i(txHoldFull),
		.txLost_i    (txLost),
		.txIdle_i    (txIdle),
		.rxTake_o    (rxTake),
		.rxChar_i    (rxChar),
		.rxFull_i    (rxFull),
		.overrun_i   (overrun),
		.txSerial_i  (txSerial),
		.rxd_i       (rxd_i),
		.rxLine_o    (rxLine),
		.txd_o       (txd_o),
		.irq_o       (irq_o)
	);

endmodule

//--- testbench/uartTbModel.svh
// ----------------------------------------------------------------------
// Reference model for the serial port testbench
//   shadow copies of CMD, CTRL and the divisor
//   word length, parity and frame image of a character
//   expected status byte while the transmitter is quiet
// ----------------------------------------------------------------------
`ifndef UART_TB_MODEL_SVH
`define UART_TB_MODEL_SVH

logic [7:0]  mCmd;
logic [7:0]  mCtrl;
logic [15:0] mDiv;

function automatic void modelReset();
	mCmd  = 8'h00;	// no parity, no irq, no loopback
	mCtrl = 8'h00;	// 8 bits, one stop
	mDiv  = 16'(DEF_DIV);
endfunction

function automatic void modelWrite(input logic [2:0] adr, input logic [7:0] dat);
	case (adr)
		uartHostPkg::ADR_STAT:  mCmd = mCmd & 8'hE1;	// rxIe, tx control, loopback cleared
		uartHostPkg::ADR_CMD:   mCmd = dat;
		uartHostPkg::ADR_CTRL:  mCtrl = dat;
		uartHostPkg::ADR_DIVLO: mDiv[7:0] = dat;
		uartHostPkg::ADR_DIVHI: mDiv[15:8] = dat;
		default: ;	// DATA holds no model state
	endcase
endfunction

function automatic logic [7:0] modelRead(input logic [2:0] adr);
	case (adr)
		uartHostPkg::ADR_CMD:   return mCmd;
		uartHostPkg::ADR_CTRL:  return mCtrl;
		uartHostPkg::ADR_DIVLO: return mDiv[7:0];
		uartHostPkg::ADR_DIVHI: return mDiv[15:8];
		default:                return 8'h00;
	endcase
endfunction

// code 00 is 8 bits, 11 is 5
function automatic int numData();
	return 8 - int'(mCtrl[6:5]);
endfunction

function automatic logic [7:0] maskData(input logic [7:0] d);
	return d & (8'hFF >> (8 - numData()));
endfunction

// parity bit from the mode code in CMD 7:5
function automatic logic parityOf(input logic [7:0] d);
	int ones;
	ones = $countones(d);
	case (mCmd[7:5])
		3'b001:  return (ones % 2) == 0;	// odd, total count made odd
		3'b011:  return (ones % 2) == 1;	// even
		3'b101:  return 1'b1;
		3'b111:  return 1'b0;
		default: return 1'b0;
	endcase
endfunction

// start, data, optional parity, one or two stop bits
function automatic int frameLen();
	return 1 + numData() + int'(mCmd[5]) + (mCtrl[7] ? 2 : 1);
endfunction

function automatic logic [11:0] frameImage(input logic [7:0] d);
	logic [11:0] bits;
	logic [7:0]  md;
	int          n;
	n = numData();
	md = maskData(d);
	bits = '1;	// stop bits and everything after are high
	bits[0] = 1'b0;
	for (int i = 0; i < n; i++)
		bits[i + 1] = md[i];	// LSB first
	if (mCmd[5])
		bits[n + 1] = parityOf(md);
	return bits;
endfunction

// irq off, transmitter idle and empty
function automatic logic [7:0] expStat(input logic rxFull, input logic ovr,
	input logic pe, input logic fe, input logic lost);
	return {1'b0, 1'b1, lost, 1'b1, rxFull, ovr, fe, pe};
endfunction

`endif

//--- testbench/uartTb.sv
// ----------------------------------------------------------------------
// Testbench for the serial port controller
//   clock, reset and single-cycle bus tasks
//   frame decoder on txd_o, frame driver on rxd_i
//   register, transmit, loopback, receive error, irq and overflow tests
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module uartTb;

	localparam int DIV_BITS = 16;
	localparam int DEF_DIV  = 3;	// short frames
	localparam int POLL_MAX = 500;	// status reads per wait
	localparam int WAIT_MAX = 4000;	// clocks per wait

	logic                 clk;
	logic                 rst;
	uartHostPkg::busReq_t bus;
	logic [7:0]           rdat;
	logic                 rxd;
	logic                 txd;
	logic                 irq;

	integer seed;
	int     checkCnt;
	int     errCnt;
	int     timeoutCnt;

	`include "uartTbModel.svh"

	uartTop #(
		.pDivBits   (DIV_BITS),
		.pDefaultDiv(DEF_DIV)
	) dut (
		.clk_i (clk),
		.rst_i (rst),
		.bus_i (bus),
		.rdat_o(rdat),
		.rxd_i (rxd),
		.txd_o (txd),
		.irq_o (irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 100 MHz
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [7:0] rand8();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// one of the five legal parity codes
	function automatic logic [2:0] randParity();
		case (rand8() % 5)
			0:       return 3'b000;
			1:       return 3'b001;
			2:       return 3'b011;
			3:       return 3'b101;
			default: return 3'b111;
		endcase
	endfunction

	function automatic string regName(input logic [2:0] adr);
		case (adr)
			uartHostPkg::ADR_DATA:  return "DATA";
			uartHostPkg::ADR_STAT:  return "STAT";
			uartHostPkg::ADR_CMD:   return "CMD";
			uartHostPkg::ADR_CTRL:  return "CTRL";
			uartHostPkg::ADR_DIVLO: return "DIVLO";
			uartHostPkg::ADR_DIVHI: return "DIVHI";
			default:                return "unused";
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [11:0] exp, input logic [11:0] got);
		checkCnt++;
		assert (got === exp) else begin
			errCnt++;
			$display("ERR %s expected %h actual %h", name, exp, got);
		end
	endtask

	task automatic noteTimeout(input string what);
		timeoutCnt++;
		$display("timed out waiting for %s", what);
	endtask

	// ----------------------------------------------------------------------
	// host bus with one clock strobes
	// ----------------------------------------------------------------------
	task automatic regWrite(input uartHostPkg::regAdr_t adr, input logic [7:0] dat);
		@(posedge clk);
		bus <= '{cs: 1'b1, we: 1'b1, adr: adr, dat: dat};
		@(posedge clk);	// write lands here
		bus.cs <= 1'b0;
		modelWrite(adr, dat);
	endtask

	task automatic regRead(input uartHostPkg::regAdr_t adr, output logic [7:0] dat);
		@(posedge clk);
		bus <= '{cs: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
		@(posedge clk);	// strobe edge
		bus.cs <= 1'b0;
		@(posedge clk);
		dat = rdat;	// held since the strobe edge
	endtask

	task automatic waitStat(input logic [7:0] mask, input logic [7:0] val, input string what);
		logic [7:0] s;
		int         tries;
		tries = 0;
		regRead(uartHostPkg::ADR_STAT, s);
		while ((s & mask) != val && tries < POLL_MAX) begin
			regRead(uartHostPkg::ADR_STAT, s);
			tries++;
		end
		if ((s & mask) != val)
			noteTimeout(what);
	endtask

	task automatic waitIrq(input logic level);
		int t;
		t = 0;
		@(posedge clk);
		while (irq !== level && t < WAIT_MAX) begin
			@(posedge clk);
			t++;
		end
		if (irq !== level) begin
			if (level)
				noteTimeout("irq_o to rise");
			else
				noteTimeout("irq_o to fall");
		end
	endtask

	// ----------------------------------------------------------------------
	// serial line
	// ----------------------------------------------------------------------
	task automatic decodeFrame(output logic [11:0] bits);
		int t;
		int n;
		int bitClk;
		bits = '1;
		t = 0;
		n = frameLen();
		bitClk = 16 * int'(mDiv);
		@(posedge clk);
		while (txd !== 1'b0 && t < WAIT_MAX) begin	// falling edge is the start bit
			@(posedge clk);
			t++;
		end
		if (txd !== 1'b0) begin
			noteTimeout("start bit on txd_o");
		end else begin
			repeat (bitClk / 2 - 1) @(posedge clk);	// middle of start bit
			bits[0] = txd;
			for (int i = 1; i < n; i++) begin
				repeat (bitClk) @(posedge clk);
				bits[i] = txd;
			end
		end
	endtask

	task automatic driveFrame(input logic [7:0] d, input logic badPar, input logic badStop);
		logic [11:0] bits;
		int          n;
		int          bitClk;
		bits = frameImage(d);
		n = frameLen();
		bitClk = 16 * int'(mDiv);
		if (badPar)
			bits[numData() + 1] = ~bits[numData() + 1];
		if (badStop)
			bits[n - 1] = 1'b0;	// last stop bit low
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			rxd <= bits[i];
			repeat (bitClk - 1) @(posedge clk);
		end
		@(posedge clk);
		rxd <= 1'b1;
		repeat (bitClk - 1) @(posedge clk);	// one idle bit
	endtask

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------
	task automatic testRegisters();
		logic [7:0] got;
		logic [2:0] adr;
		checkValue("rdat_o", 12'h000, 12'(rdat));	// nothing read yet
		for (int a = 2; a < 6; a++) begin	// CMD through DIVHI
			regRead(3'(a), got);
			checkValue(regName(3'(a)), modelRead(3'(a)), got);
		end
		regRead(uartHostPkg::ADR_STAT, got);
		checkValue("STAT", expStat(0, 0, 0, 0, 0), got);
		for (int i = 0; i < 16; i++) begin
			adr = 3'(2 + rand8() % 4);
			regWrite(adr, rand8());
			regRead(adr, got);
			checkValue(regName(adr), modelRead(adr), got);
		end
		regWrite(uartHostPkg::ADR_CMD, 8'h00);
		regWrite(uartHostPkg::ADR_CTRL, 8'h00);
		regWrite(uartHostPkg::ADR_DIVLO, 8'(DEF_DIV));
		regWrite(uartHostPkg::ADR_DIVHI, 8'h00);
	endtask

	task automatic testTxFraming();
		logic [7:0]  d;
		logic [11:0] got;
		for (int i = 0; i < 10; i++) begin
			regWrite(uartHostPkg::ADR_DIVLO, 8'(2 + rand8() % 3));
			regWrite(uartHostPkg::ADR_CTRL, rand8());	// length, stops and spare bits
			regWrite(uartHostPkg::ADR_CMD, {randParity(), 5'b00000});
			d = rand8();
			fork
				decodeFrame(got);
				regWrite(uartHostPkg::ADR_DATA, d);
			join
			checkValue("txd_o frame", frameImage(d), got);
			waitStat(8'h50, 8'h50, "transmitter idle");
		end
		regWrite(uartHostPkg::ADR_DIVLO, 8'(DEF_DIV));
	endtask

	task automatic testLoopback();
		logic [7:0] d;
		logic [7:0] got;
		int         lowCnt;
		logic       done;
		for (int i = 0; i < 5; i++) begin
			regWrite(uartHostPkg::ADR_CTRL, rand8());
			regWrite(uartHostPkg::ADR_CMD, {randParity(), 5'b10000});	// loopback on
			d = rand8();
			lowCnt = 0;
			done = 1'b0;
			fork
				begin
					regWrite(uartHostPkg::ADR_DATA, d);
					waitStat(8'h08, 8'h08, "loopback character");
					regRead(uartHostPkg::ADR_STAT, got);
					checkValue("STAT rx bits", 8'h08, got & 8'h0F);	// full and error free
					regRead(uartHostPkg::ADR_DATA, got);
					checkValue("DATA", maskData(d), got);
					waitStat(8'h5F, 8'h50, "loopback idle");
					done = 1'b1;
				end
				begin
					while (!done) begin	// pin must stay idle
						@(posedge clk);
						if (txd !== 1'b1)
							lowCnt++;
					end
				end
			join
			checkValue("txd_o low clocks", 12'h000, 12'(lowCnt));
		end
		regWrite(uartHostPkg::ADR_CMD, 8'h00);
		regWrite(uartHostPkg::ADR_CTRL, 8'h00);
	endtask

	task automatic testRxErrors();
		logic [7:0] d0;
		logic [7:0] d1;
		logic [7:0] got;
		regWrite(uartHostPkg::ADR_CMD, 8'h60);	// even parity
		// wrong parity
		d0 = rand8();
		driveFrame(d0, 1'b1, 1'b0);
		waitStat(8'h08, 8'h08, "character with bad parity");
		regRead(uartHostPkg::ADR_STAT, got);
		checkValue("STAT", expStat(1, 0, 1, 0, 0), got);
		regRead(uartHostPkg::ADR_DATA, got);
		checkValue("DATA", maskData(d0), got);
		regRead(uartHostPkg::ADR_STAT, got);
		checkValue("STAT", expStat(0, 0, 0, 0, 0), got);
		// low stop bit
		d0 = rand8();
		driveFrame(d0, 1'b0, 1'b1);
		waitStat(8'h08, 8'h08, "character with bad stop bit");
		regRead(uartHostPkg::ADR_STAT, got);
		checkValue("STAT", expStat(1, 0, 0, 1, 0), got);
		regRead(uartHostPkg::ADR_DATA, got);
		checkValue("DATA", maskData(d0), got);
		// two frames without a read between
		d0 = rand8();
		d1 = rand8();
		driveFrame(d0, 1'b0, 1'b0);
		driveFrame(d1, 1'b0, 1'b0);
		waitStat(8'h04, 8'h04, "overrun");
		regRead(uartHostPkg::ADR_STAT, got);
		checkValue("STAT", expStat(1, 1, 0, 0, 0), got);
		regRead(uartHostPkg::ADR_DATA, got);
		checkValue("DATA", maskData(d0), got);	// first byte kept
		regRead(uartHostPkg::ADR_STAT, got);
		checkValue("STAT", expStat(0, 0, 0, 0, 0), got);
		regWrite(uartHostPkg::ADR_CMD, 8'h00);
	endtask

	task automatic testIrq();
		logic [7:0] d;
		logic [7:0] got;
		regWrite(uartHostPkg::ADR_CMD, 8'h02);	// rxIe only
		@(posedge clk);
		checkValue("irq_o", 12'h000, 12'(irq));
		d = rand8();
		driveFrame(d, 1'b0, 1'b0);
		waitIrq(1'b1);
		regRead(uartHostPkg::ADR_DATA, got);
		checkValue("DATA", maskData(d), got);
		waitIrq(1'b0);
		regWrite(uartHostPkg::ADR_CMD, 8'h06);	// plus txIe while the hold register is empty
		waitIrq(1'b1);
		regWrite(uartHostPkg::ADR_STAT, rand8());	// soft reset of the enables
		waitIrq(1'b0);
		regRead(uartHostPkg::ADR_CMD, got);
		checkValue("CMD", modelRead(uartHostPkg::ADR_CMD), got);
	endtask

	task automatic testTxOverflow();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  c;
		logic [7:0]  s;
		logic [11:0] g0;
		logic [11:0] g1;
		a = rand8();
		b = rand8();
		c = rand8();
		fork
			begin
				decodeFrame(g0);
				decodeFrame(g1);
			end
			begin
				regWrite(uartHostPkg::ADR_DATA, a);
				waitStat(8'h10, 8'h10, "first byte taken");	// frame now running
				regWrite(uartHostPkg::ADR_DATA, b);
				regWrite(uartHostPkg::ADR_DATA, c);	// no room so it is dropped
				regRead(uartHostPkg::ADR_STAT, s);
				checkValue("STAT.txLost", 12'h001, 12'(s[5]));
			end
		join
		checkValue("txd_o frame 1", frameImage(a), g0);
		checkValue("txd_o frame 2", frameImage(b), g1);
		waitStat(8'h50, 8'h50, "transmitter idle");
		regRead(uartHostPkg::ADR_STAT, s);
		checkValue("STAT", expStat(0, 0, 0, 0, 0), s);	// lost cleared by the take of b
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		seed = 32'h019a9291;
		checkCnt = 0;
		errCnt = 0;
		timeoutCnt = 0;
		rst = 1'b1;
		bus = '0;
		rxd = 1'b1;	// line idle
		modelReset();
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		testRegisters();
		testTxFraming();
		testLoopback();
		testRxErrors();
		testIrq();
		testTxOverflow();

		$display("checks %0d, value errors %0d, timeouts %0d", checkCnt, errCnt, timeoutCnt);
		if (errCnt == 0 && timeoutCnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+testbench
logic/uartLinePkg.sv
logic/uartHostPkg.sv
logic/uartHoldReg.sv
logic/uartBaudGen.sv
logic/uartTx.sv
logic/uartRx.sv
logic/uartRegs.sv
logic/uartTop.sv
testbench/uartTb.sv

//--- Makefile
# Verilator build and run for the serial port controller testbench

SIM      ?= verilator
TOP      ?= uartTb
FLIST    ?= sim.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log
SIMFLAGS ?= --binary --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)

# the log decides pass or fail
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
